/* source/iic_pkg.sv */
`default_nettype none

package iic_pkg;

	localparam int DEV_ADDR_W = 7;
	localparam int REG_ADDR_W = 8;
	localparam int DATA_W     = 8;
	localparam int CMD_W      = DEV_ADDR_W + REG_ADDR_W + DATA_W; // dev, reg, data
	localparam int BYTE_W     = 8;

	localparam int FIFO_DEPTH  = 4;
	localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);
	localparam logic [FIFO_PTR_W-1:0] FIFO_PTR_LAST = FIFO_PTR_W'(FIFO_DEPTH - 1);
	localparam logic [FIFO_CNT_W-1:0] FIFO_FULL_CNT = FIFO_CNT_W'(FIFO_DEPTH);

	localparam int SCL_DIV    = 64;
	localparam int SCL_CNT_W  = $clog2(SCL_DIV);
	// start, three bytes each with its ack, stop
	localparam int FRAME_BITS = 2 + (DEV_ADDR_W + 2) + (REG_ADDR_W + 1) + (DATA_W + 1);

	// phase points inside one bit period
	localparam logic [SCL_CNT_W-1:0] PH_DRIVE      = SCL_CNT_W'(SCL_DIV / 4);
	localparam logic [SCL_CNT_W-1:0] PH_RISE       = SCL_CNT_W'(SCL_DIV / 2 - 1);
	localparam logic [SCL_CNT_W-1:0] PH_START_FALL = SCL_CNT_W'(SCL_DIV / 2);
	localparam logic [SCL_CNT_W-1:0] PH_SAMPLE     = SCL_CNT_W'(3 * SCL_DIV / 4 - 1);
	localparam logic [SCL_CNT_W-1:0] PH_STOP_REL   = SCL_CNT_W'(3 * SCL_DIV / 4);
	localparam logic [SCL_CNT_W-1:0] PH_LAST       = SCL_CNT_W'(SCL_DIV - 1);

	localparam int BIT_CNT_W = $clog2(BYTE_W);
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(BYTE_W - 1);

	typedef enum logic [3:0] {
		IDLE,
		START,
		DEVICE_ADDR, // 7 address bits then the write bit
		DEVICE_ADDR_ACK,
		REGISTER_ADDR,
		REGISTER_ADDR_ACK,
		WRITE_DATA,
		WRITE_DATA_ACK,
		STOP
	} tx_state_t;

endpackage : iic_pkg

`default_nettype wire

/* source/iic_cmd_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module iic_cmd_gen (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          wr,
	input  logic                          auto_inc,
	input  logic [iic_pkg::DEV_ADDR_W-1:0] device_addr,
	input  logic [iic_pkg::REG_ADDR_W-1:0] reg_addr,
	input  logic [iic_pkg::DATA_W-1:0]     data,
	input  logic                          full,
	output logic                          push,
	output logic [iic_pkg::CMD_W-1:0]      push_cmd,
	output logic                          overflow
);

	import iic_pkg::*;

	logic [REG_ADDR_W-1:0] last_reg;
	logic [REG_ADDR_W-1:0] eff_reg;

	// auto increment wraps naturally at the register width
	assign eff_reg  = auto_inc ? last_reg + 1'b1 : reg_addr;
	assign push     = wr & ~full;
	assign push_cmd = {device_addr, eff_reg, data};

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			last_reg <= '0;
		end else if (push) begin
			last_reg <= eff_reg; // base for the next auto write
		end
	end

	// sticky, cleared only by reset
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			overflow <= 1'b0;
		end else if (wr && full) begin
			overflow <= 1'b1;
		end
	end

endmodule : iic_cmd_gen

`default_nettype wire

/* source/iic_cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module iic_cmd_fifo (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     push,
	input  logic [iic_pkg::CMD_W-1:0] push_cmd,
	input  logic                     pop,
	output logic [iic_pkg::CMD_W-1:0] pop_cmd,
	output logic                     empty,
	output logic                     full
);

	import iic_pkg::*;

	logic [CMD_W-1:0]      mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;

	function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
		return (ptr == FIFO_PTR_LAST) ? '0 : ptr + 1'b1;
	endfunction

	assign pop_cmd = mem[rd_ptr]; // oldest entry
	assign empty   = (count == '0);
	assign full    = (count == FIFO_FULL_CNT);

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or push with pop
			endcase
		end
	end

endmodule : iic_cmd_fifo

`default_nettype wire

/* source/iic_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module iic_tx (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     empty,
	input  logic [iic_pkg::CMD_W-1:0] pop_cmd,
	output logic                     pop,
	output logic                     busy,
	output logic                     nack,
	output logic                     scl,
	inout  wire                      sda
);

	import iic_pkg::*;

	tx_state_t              state;
	logic [CMD_W-1:0]       cmd;
	logic [SCL_CNT_W-1:0]   clk_count;
	logic [BIT_CNT_W-1:0]   bit_cnt;
	logic [BYTE_W-1:0]      tx_byte;
	logic                   sda_low;
	logic                   nack_pend;

	// open drain, the pull-up gives the high level
	assign sda  = sda_low ? 1'b0 : 1'bz;
	assign busy = (state != IDLE);
	assign pop  = (state == IDLE) && !empty;

	always_comb begin
		case (state)
			DEVICE_ADDR:   tx_byte = {cmd[CMD_W-1 -: DEV_ADDR_W], 1'b0}; // write bit
			REGISTER_ADDR: tx_byte = cmd[DATA_W +: REG_ADDR_W];
			default:       tx_byte = cmd[DATA_W-1:0];
		endcase
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			cmd <= pop_cmd;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state     <= IDLE;
			scl       <= 1'b1;
			sda_low   <= 1'b0;
			clk_count <= '0;
			bit_cnt   <= '0;
			nack_pend <= 1'b0;
			nack      <= 1'b0;
		end else begin
			nack <= 1'b0;
			if (state == IDLE || clk_count == PH_LAST) begin
				clk_count <= '0;
			end else begin
				clk_count <= clk_count + 1'b1;
			end
			case (state)
				IDLE: begin
					scl     <= 1'b1;
					sda_low <= 1'b0;
					if (!empty) begin
						state     <= START;
						nack_pend <= 1'b0;
					end
				end
				START: begin
					if (clk_count == PH_DRIVE) begin
						sda_low <= 1'b1; // start condition, scl still high
					end else if (clk_count == PH_START_FALL) begin
						scl <= 1'b0;
					end else if (clk_count == PH_LAST) begin
						state   <= DEVICE_ADDR;
						bit_cnt <= '0;
					end
				end
				DEVICE_ADDR, REGISTER_ADDR, WRITE_DATA: begin
					if (clk_count == PH_DRIVE) begin
						sda_low <= ~tx_byte[BIT_LAST - bit_cnt]; // msb first
					end else if (clk_count == PH_RISE) begin
						scl <= 1'b1;
					end else if (clk_count == PH_LAST) begin
						scl <= 1'b0;
						if (bit_cnt == BIT_LAST) begin
							sda_low <= 1'b0; // hand sda to the slave
							case (state)
								DEVICE_ADDR:   state <= DEVICE_ADDR_ACK;
								REGISTER_ADDR: state <= REGISTER_ADDR_ACK;
								default:       state <= WRITE_DATA_ACK;
							endcase
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				DEVICE_ADDR_ACK, REGISTER_ADDR_ACK, WRITE_DATA_ACK: begin
					if (clk_count == PH_RISE) begin
						scl <= 1'b1;
					end else if (clk_count == PH_SAMPLE) begin
						if (sda) begin
							nack_pend <= 1'b1; // released line means nack
						end
					end else if (clk_count == PH_LAST) begin
						scl     <= 1'b0;
						bit_cnt <= '0;
						if (nack_pend || state == WRITE_DATA_ACK) begin
							state <= STOP;
						end else if (state == DEVICE_ADDR_ACK) begin
							state <= REGISTER_ADDR;
						end else begin
							state <= WRITE_DATA;
						end
					end
				end
				STOP: begin
					if (clk_count == PH_DRIVE) begin
						sda_low <= 1'b1;
					end else if (clk_count == PH_RISE) begin
						scl <= 1'b1;
					end else if (clk_count == PH_STOP_REL) begin
						sda_low <= 1'b0; // stop condition, scl high
					end else if (clk_count == PH_LAST) begin
						state <= IDLE;
						nack  <= nack_pend;
					end
				end
				default: begin
					state   <= IDLE;
					scl     <= 1'b1;
					sda_low <= 1'b0;
				end
			endcase
		end
	end

endmodule : iic_tx

`default_nettype wire

/* source/iic_write_top.sv */
`timescale 1ns/1ps
`default_nettype none

module iic_write_top (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          wr,
	input  logic                          auto_inc,
	input  logic [iic_pkg::DEV_ADDR_W-1:0] device_addr,
	input  logic [iic_pkg::REG_ADDR_W-1:0] reg_addr,
	input  logic [iic_pkg::DATA_W-1:0]     data,
	output logic                          busy,
	output logic                          nack,
	output logic                          overflow,
	output logic                          scl,
	inout  wire                           sda
);

	import iic_pkg::*;

	logic             push;
	logic [CMD_W-1:0] push_cmd;
	logic             full;
	logic             pop;
	logic [CMD_W-1:0] pop_cmd;
	logic             empty;

	iic_cmd_gen iic_cmd_gen_inst (
		.clk         (clk),
		.rstn        (rstn),
		.wr          (wr),
		.auto_inc    (auto_inc),
		.device_addr (device_addr),
		.reg_addr    (reg_addr),
		.data        (data),
		.full        (full),
		.push        (push),
		.push_cmd    (push_cmd),
		.overflow    (overflow)
	);

	iic_cmd_fifo iic_cmd_fifo_inst (
		.clk      (clk),
		.rstn     (rstn),
		.push     (push),
		.push_cmd (push_cmd),
		.pop      (pop),
		.pop_cmd  (pop_cmd),
		.empty    (empty),
		.full     (full)
	);

	iic_tx iic_tx_inst (
		.clk     (clk),
		.rstn    (rstn),
		.empty   (empty),
		.pop_cmd (pop_cmd),
		.pop     (pop),
		.busy    (busy),
		.nack    (nack),
		.scl     (scl),
		.sda     (sda)
	);

endmodule : iic_write_top

`default_nettype wire

/* testbench/iic_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

module iic_slave_model #(
	parameter logic [6:0] OWN_ADDR = 7'h3C
) (
	input  logic       clk,
	input  logic       scl,
	inout  wire        sda,
	output logic       frame_done,
	output logic [6:0] rx_dev,
	output logic [7:0] rx_reg,
	output logic [7:0] rx_data,
	output logic [3:0] rx_bytes
);

	logic       scl_q = 1'b1;
	logic       sda_q = 1'b1;
	logic       sda_low = 1'b0;
	logic       in_frame = 1'b0;
	logic       matched = 1'b0;
	logic       addr_hit;
	logic [7:0] shift = '0;
	logic [3:0] bit_cnt = '0;
	logic [3:0] byte_cnt = '0;

	assign sda      = sda_low ? 1'b0 : 1'bz;
	assign addr_hit = (shift == {OWN_ADDR, 1'b0}); // own address, write bit

	// bus oversampled on the system clock
	always @(posedge clk) begin
		scl_q      <= scl;
		sda_q      <= sda;
		frame_done <= 1'b0;
		if (scl && scl_q && sda_q && !sda) begin // start
			in_frame <= 1'b1;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			rx_reg   <= '0;
			rx_data  <= '0;
		end else if (in_frame && scl && scl_q && !sda_q && sda) begin // stop
			in_frame   <= 1'b0;
			frame_done <= 1'b1;
			rx_bytes   <= byte_cnt;
		end else if (in_frame && scl && !scl_q) begin
			if (bit_cnt == 4'd8) begin
				bit_cnt <= '0; // ack clock
			end else begin
				shift   <= {shift[6:0], sda};
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else if (in_frame && !scl && scl_q) begin
			sda_low <= 1'b0;
			if (bit_cnt == 4'd8) begin
				byte_cnt <= byte_cnt + 1'b1;
				if (byte_cnt == 4'd0) begin
					rx_dev  <= shift[7:1];
					matched <= addr_hit;
					sda_low <= addr_hit;
				end else begin
					sda_low <= matched;
					if (byte_cnt == 4'd1) begin
						rx_reg <= shift;
					end else begin
						rx_data <= shift;
					end
				end
			end
		end
	end

endmodule : iic_slave_model

`default_nettype wire

/* testbench/iic_write_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module iic_write_tb;

	import iic_pkg::*;

	localparam int WAIT_LIMIT = 2 * FRAME_BITS * SCL_DIV;

	logic                  clk = 1'b0;
	logic                  rstn;
	logic                  wr;
	logic                  auto_inc;
	logic [DEV_ADDR_W-1:0] device_addr;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic [DATA_W-1:0]     data;
	logic                  busy;
	logic                  nack;
	logic                  overflow;
	logic                  scl;
	wire                   sda;
	logic                  frame_done;
	logic [6:0]            rx_dev;
	logic [7:0]            rx_reg;
	logic [7:0]            rx_data;
	logic [3:0]            rx_bytes;
	logic [31:0]           got [$]; // bytes, dev, reg, data per frame
	logic [31:0]           g [13];  // fields of one golden line
	int                    nack_count;
	int                    errors = 0;
	int                    tests = 0;

	pullup (sda);

	always #10 clk = ~clk;

	iic_write_top iic_write_top_inst (
		.clk         (clk),
		.rstn        (rstn),
		.wr          (wr),
		.auto_inc    (auto_inc),
		.device_addr (device_addr),
		.reg_addr    (reg_addr),
		.data        (data),
		.busy        (busy),
		.nack        (nack),
		.overflow    (overflow),
		.scl         (scl),
		.sda         (sda)
	);

	iic_slave_model #(.OWN_ADDR(7'h3C)) iic_slave_model_inst (
		.clk        (clk),
		.scl        (scl),
		.sda        (sda),
		.frame_done (frame_done),
		.rx_dev     (rx_dev),
		.rx_reg     (rx_reg),
		.rx_data    (rx_data),
		.rx_bytes   (rx_bytes)
	);

	// sampled away from the active edge
	always @(negedge clk) begin
		if (frame_done) begin
			got.push_back({4'b0, rx_bytes, 1'b0, rx_dev, rx_reg, rx_data});
		end
		if (nack) begin
			nack_count++;
		end
	end

	task automatic mismatch(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		$display("** Error: test %0d %s expected %h actual %h", g[0], name, exp_val, act_val);
		errors++;
	endtask

	task automatic play_line();
		int k;
		int waited;
		int errors_before;
		errors_before = errors;
		nack_count = 0;
		got.delete();
		for (k = 0; k < int'(g[1]); k++) begin
			wr          <= 1'b1;
			auto_inc    <= g[2][0];
			device_addr <= g[3][6:0];
			reg_addr    <= g[4][7:0];
			data        <= 8'(g[5] + k); // data rises by one per strobe
			@(posedge clk);
		end
		wr       <= 1'b0;
		auto_inc <= 1'b0;
		for (k = 0; k < int'(g[6]); k++) begin
			waited = 0;
			while (got.size() <= k && waited < WAIT_LIMIT) begin
				@(posedge clk);
				waited++;
			end
			if (got.size() <= k) begin
				$display("test %0d: timed out waiting for frame %0d at the slave", g[0], k);
				errors++;
			end
		end
		waited = 0;
		while (busy !== 1'b0 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (busy !== 1'b0) begin
			$display("test %0d: timed out waiting for busy to fall", g[0]);
			errors++;
		end
		@(posedge clk);
		if (got.size() != int'(g[6])) begin
			$display("test %0d: slave saw %0d frames instead of %0d", g[0], got.size(), g[6]);
			errors++;
		end
		for (k = 0; k < got.size() && k < int'(g[6]); k++) begin
			if (got[k][27:24] !== g[10][3:0]) mismatch("rx_bytes", g[10], 32'(got[k][27:24]));
			if (got[k][22:16] !== g[7][6:0]) mismatch("rx_dev", g[7], 32'(got[k][22:16]));
			if (g[10] > 1 && got[k][15:8] !== g[8][7:0]) mismatch("rx_reg", g[8], 32'(got[k][15:8]));
			if (g[10] > 2 && got[k][7:0] !== 8'(g[9] + k)) begin
				mismatch("rx_data", 32'(8'(g[9] + k)), 32'(got[k][7:0]));
			end
		end
		if (scl !== 1'b1) mismatch("scl", 32'd1, 32'(scl));
		if (sda !== 1'b1) mismatch("sda", 32'd1, 32'(sda));
		if (busy !== 1'b0) mismatch("busy", 32'd0, 32'(busy));
		if (nack_count != int'(g[11])) mismatch("nack pulses", g[11], nack_count);
		if (overflow !== g[12][0]) mismatch("overflow", g[12], 32'(overflow));
		tests++;
		$display("test %0d %s", g[0], (errors == errors_before) ? "ok" : "FAILED");
	endtask

	initial begin
		int    fd;
		int    n;
		string line;
		rstn        = 1'b0;
		wr          = 1'b0;
		auto_inc    = 1'b0;
		device_addr = '0;
		reg_addr    = '0;
		data        = '0;
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		fd = $fopen("testbench/iic_write_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
					g[0], g[1], g[2], g[3], g[4], g[5], g[6],
					g[7], g[8], g[9], g[10], g[11], g[12]);
				if (n == 13) begin
					play_line();
				end else if (n > 0) begin
					$display("golden line not understood: %s", line);
					errors++;
				end
			end
			$fclose(fd);
		end
		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule : iic_write_tb

`default_nettype wire

/* testbench/iic_write_golden.txt */
# test wr_cnt auto dev reg data | frames exp_dev exp_reg exp_data exp_bytes nack overflow
# all hex; wr_cnt strobes on consecutive cycles with data rising by one, 0 checks the idle bus
0 0 0 00 00 00 0 00 00 00 0 0 0
1 1 0 3c 10 a5 1 3c 10 a5 3 0 0
2 1 0 3c 40 01 1 3c 40 01 3 0 0
3 1 1 3c 55 02 1 3c 41 02 3 0 0
4 1 1 3c 66 03 1 3c 42 03 3 0 0
5 1 0 3c ff 5a 1 3c ff 5a 3 0 0
6 1 1 3c 77 5b 1 3c 00 5b 3 0 0
7 1 0 11 20 99 1 11 00 00 1 1 0
8 1 0 3c 21 c3 1 3c 21 c3 3 0 0
9 6 0 3c 30 e0 5 3c 30 e0 3 0 1

/* iic_write_top.f */
source/iic_pkg.sv
source/iic_cmd_gen.sv
source/iic_cmd_fifo.sv
source/iic_tx.sv
source/iic_write_top.sv
testbench/iic_slave_model.sv
testbench/iic_write_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= iic_write_tb
RTL_TOP   ?= iic_write_top
FILELIST  ?= iic_write_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
